/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = neopixelTb
FILELIST  = sim.f
OBJDIR    = obj_dir
SIMBIN    = $(OBJDIR)/V$(TOP)
PASSTEXT  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: compile
	@output="$$(./$(SIMBIN))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

/* hw/neopixel_pixel_buffer.sv */
`timescale 1ns/1ns
`include "neopixel_config.svh"

// frame storage, one byte per address
// the sequencer holds busy during a frame so the data cannot change under the encoder
module neopixelPixelBuffer (
  input  logic                     clk,
  input  logic                     reset,
  input  neopixelPkg::pixelWrite_t pixelWrite, // byte write strobe from outside
  input  logic                     busy,       // frame in progress
  output neopixelPkg::pixelArray_t pixels      // whole frame to the encoder
);

  logic inRange;     // address falls inside the buffer
  logic writeAccept; // write really lands in the array

  // the address type may be wider than the buffer when BUFFER_END+1 is not a power of two
  assign inRange = int'(pixelWrite.address) <= `BUFFER_END;

  // writes are dropped while a frame is sent or when they point past the end
  assign writeAccept = pixelWrite.enable && inRange && !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      pixels <= '0; // every pixel starts dark
    end else if (writeAccept) begin
      pixels[pixelWrite.address] <= pixelWrite.data; // visible on the next edge
    end
  end

  // in 32-bit mode every fourth byte is padding and is simply never read
  // in 8-bit mode each byte is a full pixel, so all addresses get used

  // no byte may change while the sequencer reports a frame in progress
  // busy comes from the sequencer, so this ties the two blocks together
  noWriteWhileBusy: assert property (
    @(posedge clk) disable iff (reset)
    busy |=> $stable(pixels)
  ) else $error("pixel buffer changed during a frame");

endmodule

/* hw/neopixel_pkg.sv */
`include "neopixel_config.svh"

package neopixelPkg;

  typedef logic [7:0] pixelByte_t; // one byte of the buffer

  // byte address, wide enough to reach BUFFER_END
  typedef logic [$clog2(`BUFFER_END + 1)-1:0] bufferIndex_t;

  // the whole frame as one packed vector of bytes
  typedef pixelByte_t [`BUFFER_END:0] pixelArray_t;

  typedef logic [1:0] channel_t;   // 0 green, 1 blue, 2 red
  typedef logic [2:0] bitIndex_t;  // bit 0 of a channel is sent first
  typedef logic [2:0] slotIndex_t; // slot inside the eight slot pattern

  typedef enum logic [1:0] {
    IDLE,     // waiting for a start pulse
    TRANSMIT, // shifting the pixel bits out on the line
    LATCH     // line held low so the strip takes over the frame
  } seqState_t;

  // where the sequencer is inside the frame
  typedef struct packed {
    bufferIndex_t pixelIndex;      // byte address of the current pixel
    channel_t     channelIndex;    // colour channel being sent
    bitIndex_t    pixelBitIndex;   // bit inside the channel
    slotIndex_t   bitPatternIndex; // slot inside the bit pattern
  } streamPosition_t;

  // one byte write into the buffer, the enable is a single cycle strobe
  typedef struct packed {
    logic         enable;
    bufferIndex_t address;
    pixelByte_t   data;
  } pixelWrite_t;

endpackage

/* hw/neopixel_sequencer.sv */
`timescale 1ns/1ns
`include "neopixel_config.svh"

// frame sequencer
// walks slots, bits, channels and pixels, then holds the latch period
module neopixelSequencer (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,         // one cycle launch pulse
  input  logic                         mode32,        // buffer layout, sampled at start
  output neopixelPkg::seqState_t       state,
  output neopixelPkg::streamPosition_t position,      // current point inside the frame
  output logic                         mode32Latched, // layout used for this frame
  output logic                         busy,
  output logic                         frameDone      // one cycle pulse at latch end
);

  localparam int SLOT_BITS  = $clog2(`SLOT_CYCLES + 1);
  localparam int LATCH_BITS = $clog2(`LATCH_CYCLES + 1);

  logic [SLOT_BITS-1:0]  slotCount;  // clocks spent in the current slot
  logic [LATCH_BITS-1:0] latchCount; // clocks spent in the latch period

  logic slotTick;    // last clock of a slot
  logic lastSlot;    // final slot of a bit pattern
  logic lastBit;     // final bit of a channel
  logic lastChannel; // red is the last channel of a pixel
  logic lastPixel;   // no further pixel fits into the buffer
  logic latchEnd;    // last clock of the latch period
  int   pixelStep;   // bytes per pixel for the latched layout

  neopixelPkg::bufferIndex_t nextPixel;

  assign slotTick    = slotCount == SLOT_BITS'(`SLOT_CYCLES - 1);
  assign lastSlot    = position.bitPatternIndex == 3'd7;
  assign lastBit     = position.pixelBitIndex == 3'd7;
  assign lastChannel = position.channelIndex == 2'd2;
  assign latchEnd    = latchCount == LATCH_BITS'(`LATCH_CYCLES - 1);

  always_comb begin
    // four bytes per pixel in 32-bit mode, one byte when packed
    pixelStep = mode32Latched ? 4 : 1;
    nextPixel = position.pixelIndex + neopixelPkg::bufferIndex_t'(pixelStep);
    // the frame ends when the following pixel would start past the buffer
    lastPixel = (int'(position.pixelIndex) + pixelStep) > `BUFFER_END;
  end

  assign busy = state != neopixelPkg::IDLE; // rises the cycle after start

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= neopixelPkg::IDLE;
      position      <= '0;
      slotCount     <= '0;
      latchCount    <= '0;
      mode32Latched <= 1'b0;
      frameDone     <= 1'b0;
    end else begin
      frameDone <= 1'b0; // only the latch end raises it, for a single cycle

      case (state)
        neopixelPkg::IDLE: begin
          // a start pulse elsewhere is ignored, the frame in flight keeps going
          if (start) begin
            state         <= neopixelPkg::TRANSMIT;
            mode32Latched <= mode32; // the layout stays fixed for the whole frame
            position      <= '0;
            slotCount     <= '0;
          end
        end

        neopixelPkg::TRANSMIT: begin
          if (slotTick) begin
            slotCount                <= '0;
            position.bitPatternIndex <= position.bitPatternIndex + 3'd1; // wraps after slot 7

            if (lastSlot) begin
              // one data bit is done, move to the next bit of the channel
              position.pixelBitIndex <= position.pixelBitIndex + 3'd1;

              if (lastBit) begin
                if (lastChannel) begin
                  position.channelIndex <= '0; // back to green for the next pixel
                  if (lastPixel) begin
                    // everything is out, hold the line low for the latch
                    state               <= neopixelPkg::LATCH;
                    latchCount          <= '0;
                    position.pixelIndex <= '0;
                  end else begin
                    position.pixelIndex <= nextPixel;
                  end
                end else begin
                  position.channelIndex <= position.channelIndex + 2'd1; // green, blue, red
                end
              end
            end
          end else begin
            slotCount <= slotCount + 1'b1;
          end
        end

        neopixelPkg::LATCH: begin
          if (latchEnd) begin
            state     <= neopixelPkg::IDLE;
            frameDone <= 1'b1;
          end else begin
            latchCount <= latchCount + 1'b1;
          end
        end

        default: state <= neopixelPkg::IDLE; // unused encoding falls back to idle
      endcase
    end
  end

  // the encoder addresses the buffer with this index, so it must stay inside it
  pixelIndexInRange: assert property (
    @(posedge clk) disable iff (reset)
    int'(position.pixelIndex) <= `BUFFER_END
  ) else $error("pixel index beyond the buffer end");

  // only green, blue and red exist
  channelIndexValid: assert property (
    @(posedge clk) disable iff (reset)
    position.channelIndex != 2'd3
  ) else $error("channel index reached 3");

  // the frame done strobe never stretches
  frameDoneSingle: assert property (
    @(posedge clk) disable iff (reset)
    frameDone |=> !frameDone
  ) else $error("frameDone longer than one cycle");

endmodule

/* hw/neopixel_stream.sv */
`timescale 1ns/1ns
`include "neopixel_config.svh"

// serial encoder
// picks the channel byte for the current position and drives the slot pattern
module neopixelStream (
  input  neopixelPkg::pixelArray_t     pixels,
  input  neopixelPkg::seqState_t       state,
  input  neopixelPkg::streamPosition_t position,
  input  logic                         mode32Latched, // 1 selects four bytes per pixel
  input  logic                         run,           // line enable
  output logic                         neoData        // serial line to the strip
);

  localparam int INDEX_BITS = $bits(neopixelPkg::bufferIndex_t);

  neopixelPkg::bufferIndex_t channelAddress; // byte of the channel in 32-bit mode
  neopixelPkg::pixelByte_t   channelByte;    // that byte as stored
  neopixelPkg::pixelByte_t   packedByte;     // whole pixel in 8-bit mode
  neopixelPkg::pixelByte_t   colourValue;    // channel value, bit 0 goes out first
  logic [7:0]                pattern;        // slot pattern for the current bit

  // pixel base has its two low bits clear, the channel index fills them in
  assign channelAddress = {position.pixelIndex[INDEX_BITS-1:2], position.channelIndex};
  assign channelByte    = pixels[channelAddress];
  assign packedByte     = pixels[position.pixelIndex];

  always_comb begin
    colourValue = '0;
    if (mode32Latched) begin
      // reverse the byte so bit index 0 picks the MSB
      // the fourth byte of each pixel is never addressed
      for (int i = 0; i < 8; i++) begin
        colourValue[i] = channelByte[7 - i];
      end
    end else begin
      // packed source is blue [7:6], green [5:3], red [2:0]
      // each field lands sparsely in the channel with its high bit sent first
      case (position.channelIndex)
        2'd1: begin
          colourValue = {4'b0000, packedByte[6], 2'b00, packedByte[7]}; // 2 bits blue
        end
        2'd2: begin
          colourValue = {2'b00, packedByte[0], 1'b0, packedByte[1], 2'b00, packedByte[2]};
        end
        default: begin
          // green, also covers the unused channel 3
          colourValue = {2'b00, packedByte[3], 1'b0, packedByte[4], 1'b0, packedByte[5], 1'b0};
        end
      endcase
    end
  end

  // long high time for a one, short for a zero
  assign pattern = colourValue[position.pixelBitIndex] ? `PATTERN_ONE : `PATTERN_ZERO;

  always_comb begin
    if (state == neopixelPkg::TRANSMIT && run) begin
      neoData = pattern[position.bitPatternIndex]; // follows the slot counter directly
    end else begin
      // idle, latch or stopped, the line stays low
      neoData = 1'b0;
    end
  end

  // with run low the sequencer still walks the frame with full timing
  // so frameDone arrives at the same time as in a visible frame
  // the encoder holds no state, every change of position shows on the line at once

endmodule

/* hw/neopixel_top.sv */
`timescale 1ns/1ns

// top level of the strip controller
// buffer, sequencer and encoder wired together
module neopixelTop (
  input  logic                     clk,
  input  logic                     reset,
  input  neopixelPkg::pixelWrite_t pixelWrite, // byte writes into the frame buffer
  input  logic                     run,        // enables the serial line
  input  logic                     mode32,     // 1 for four bytes per pixel
  input  logic                     start,      // launches one frame
  output logic                     neoData,
  output logic                     busy,
  output logic                     frameDone
);

  neopixelPkg::pixelArray_t     pixels;        // frame contents
  neopixelPkg::seqState_t       state;
  neopixelPkg::streamPosition_t position;      // sequencer position inside the frame
  logic                         mode32Latched; // layout frozen at start

  neopixelPixelBuffer bufferInst (
    .clk        (clk),
    .reset      (reset),
    .pixelWrite (pixelWrite),
    .busy       (busy), // blocks writes during a frame
    .pixels     (pixels)
  );

  neopixelSequencer sequencerInst (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .mode32        (mode32),
    .state         (state),
    .position      (position),
    .mode32Latched (mode32Latched),
    .busy          (busy),
    .frameDone     (frameDone)
  );

  neopixelStream streamInst (
    .pixels        (pixels),
    .state         (state),
    .position      (position),
    .mode32Latched (mode32Latched),
    .run           (run),
    .neoData       (neoData)
  );

endmodule

/* include/neopixel_config.svh */
`ifndef NEOPIXEL_CONFIG_SVH
`define NEOPIXEL_CONFIG_SVH

// highest byte address of the pixel buffer
// 15 gives four pixels in 32-bit mode or sixteen pixels in 8-bit mode
`define BUFFER_END 15

// clocks spent in one slot of a bit pattern
`define SLOT_CYCLES 4

// clocks the line stays low after the last bit so the strip latches the frame
`define LATCH_CYCLES 200

// eight slots per data bit, slot 0 sits in the LSB and goes out first
// a one keeps the line high for five slots
`define PATTERN_ONE 8'b00011111

// a zero keeps the line high for only two slots
`define PATTERN_ZERO 8'b00000011

// with the default slot length one bit takes 32 clocks
// both patterns start high, so every bit begins with a rising edge on the line

`endif

/* sim.f */
+incdir+include
hw/neopixel_pkg.sv
hw/neopixel_pixel_buffer.sv
hw/neopixel_sequencer.sv
hw/neopixel_stream.sv
hw/neopixel_top.sv
testbench/neopixel_checker.sv
testbench/neopixel_tb.sv

/* testbench/neopixel_checker.sv */
`timescale 1ns/1ns
`include "neopixel_config.svh"

// watches the DUT ports, decodes the serial line and compares every frame
module neopixelChecker (
  input  logic                     clk,
  input  logic                     reset,
  input  neopixelPkg::pixelWrite_t pixelWrite,
  input  logic                     run,
  input  logic                     mode32,
  input  logic                     start,
  input  logic                     neoData,
  input  logic                     busy,
  input  logic                     frameDone,
  output int                       errorCount, // follows the internal count one edge later
  output int                       frameCount  // frames that reached frameDone
);

  localparam int BIT_CLOCKS = 8 * `SLOT_CYCLES; // one data bit on the line

  neopixelPkg::pixelArray_t mirror; // buffer contents rebuilt from the accepted writes
  bit   expectedBits[$];            // what the current frame should carry, in line order
  bit   decodedBits[$];             // what was measured on neoData
  logic frameActive = 1'b0;
  logic frameWide   = 1'b0;         // layout sampled at start
  int   busyCycles  = 0;
  int   highCount   = 0;            // clocks the line has been high in the current pulse
  int   resetEdges  = 0;
  int   errors      = 0;
  int   frames      = 0;

  // four bytes per pixel in 32-bit mode, one otherwise
  function automatic int pixelCount(input logic wide);
    return wide ? (`BUFFER_END + 1) / 4 : `BUFFER_END + 1;
  endfunction

  // bit k of a frame, counted in the order it leaves on the line
  function automatic bit expectedBit(input neopixelPkg::pixelArray_t frame,
                                     input logic wide, input int k);
    int         pixel;
    int         channel;
    logic [2:0] bitPos;
    logic [7:0] source;
    logic [7:0] value; // channel value with its first bit in the MSB
    pixel   = k / 24;
    channel = (k / 8) % 3; // green, blue, red
    bitPos  = 3'(k % 8);
    if (wide) begin
      value = frame[neopixelPkg::bufferIndex_t'(pixel * 4 + channel)]; // byte 3 never used
    end else begin
      source = frame[neopixelPkg::bufferIndex_t'(pixel)];
      // each packed field goes out high bit first on sparse positions
      case (channel)
        0: value = {1'b0, source[5], 1'b0, source[4], 1'b0, source[3], 2'b00}; // green 5:3
        1: value = {source[7], 2'b00, source[6], 4'b0000};                     // blue 7:6
        default: value = {source[2], 2'b00, source[1], 1'b0, source[0], 2'b00}; // red 2:0
      endcase
    end
    return value[3'd7 - bitPos];
  endfunction

  task automatic flagMismatch(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic beginFrame();
    frameWide   = mode32;
    frameActive = 1'b1;
    busyCycles  = 0;
    expectedBits.delete();
    decodedBits.delete();
    if (run) begin // with the line disabled not a single pulse may appear
      for (int k = 0; k < pixelCount(mode32) * 24; k++) begin
        expectedBits.push_back(expectedBit(mirror, mode32, k));
      end
    end
  endtask

  task automatic compareFrame();
    int length;
    length = pixelCount(frameWide) * 24 * BIT_CLOCKS + `LATCH_CYCLES;
    if (busyCycles != length) begin
      flagMismatch($sformatf("frame lasted %0d clocks, expected %0d", busyCycles, length));
    end
    if (decodedBits.size() != expectedBits.size()) begin
      flagMismatch($sformatf("decoded %0d bits, expected %0d",
                             decodedBits.size(), expectedBits.size()));
    end else begin
      for (int i = 0; i < expectedBits.size(); i++) begin
        if (decodedBits[i] != expectedBits[i]) begin
          flagMismatch($sformatf("frame %0d bit %0d is %b, expected %b",
                                 frames, i, decodedBits[i], expectedBits[i]));
        end
      end
    end
    frames++;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      // the first edge clears the registers, from the second on all outputs are low
      if (resetEdges > 0 && (neoData || busy || frameDone)) begin
        flagMismatch($sformatf("in reset neoData %b busy %b frameDone %b",
                               neoData, busy, frameDone));
      end
      resetEdges++;
      mirror      = '0;
      frameActive = 1'b0;
      highCount   = 0;
    end else begin
      if (neoData) begin
        if (!frameActive) flagMismatch("serial line high outside a frame");
        highCount++;
      end else if (highCount > 0) begin
        // a pulse just ended, its width tells the bit
        if (highCount == 5 * `SLOT_CYCLES) begin
          decodedBits.push_back(1'b1);
        end else if (highCount == 2 * `SLOT_CYCLES) begin
          decodedBits.push_back(1'b0);
        end else begin
          flagMismatch($sformatf("high pulse of %0d clocks is no valid bit", highCount));
        end
        highCount = 0;
      end

      if (frameActive) begin
        if (frameDone) begin
          compareFrame();
          frameActive = 1'b0;
        end else begin
          if (!busy) flagMismatch("busy dropped before frameDone");
          busyCycles++;
        end
      end else if (frameDone) begin
        flagMismatch("frameDone without a frame in progress");
      end

      // the buffer takes a write only when idle and in range
      if (pixelWrite.enable && int'(pixelWrite.address) <= `BUFFER_END && !busy) begin
        mirror[pixelWrite.address] = pixelWrite.data;
      end

      if (start && !busy) beginFrame(); // a start during a frame is ignored
    end
    errorCount <= errors;
    frameCount <= frames;
  end

endmodule

/* testbench/neopixel_tb.sv */
`timescale 1ns/1ns
`include "neopixel_config.svh"

// testbench top, loads the buffer and launches frames
// every comparison happens in the checker instance
module neopixelTb;

  localparam int BIT_CLOCKS   = 8 * `SLOT_CYCLES;
  localparam int WIDE_FRAME   = ((`BUFFER_END + 1) / 4) * 24 * BIT_CLOCKS;
  localparam int NARROW_FRAME = (`BUFFER_END + 1) * 24 * BIT_CLOCKS;
  localparam int DONE_LIMIT   = NARROW_FRAME + `LATCH_CYCLES + 50; // longest frame plus margin
  localparam int BUSY_LIMIT   = 10;

  logic                     clk;
  logic                     reset;
  neopixelPkg::pixelWrite_t pixelWrite;
  logic                     run;
  logic                     mode32;
  logic                     start;
  logic                     neoData;
  logic                     busy;
  logic                     frameDone;

  int checkErrors; // counted by the checker
  int framesSeen;
  int tbErrors;    // timeouts and stray activity seen here
  int seed;

  neopixelTop dut0 (
    .clk        (clk),
    .reset      (reset),
    .pixelWrite (pixelWrite),
    .run        (run),
    .mode32     (mode32),
    .start      (start),
    .neoData    (neoData),
    .busy       (busy),
    .frameDone  (frameDone)
  );

  neopixelChecker checkInst (
    .clk        (clk),
    .reset      (reset),
    .pixelWrite (pixelWrite),
    .run        (run),
    .mode32     (mode32),
    .start      (start),
    .neoData    (neoData),
    .busy       (busy),
    .frameDone  (frameDone),
    .errorCount (checkErrors),
    .frameCount (framesSeen)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  task automatic finishRun();
    repeat (2) @(posedge clk); // lets the checker counts settle
    $display("errors: checker %0d, testbench %0d, frames compared %0d",
             checkErrors, tbErrors, framesSeen);
    if (checkErrors == 0 && tbErrors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  task automatic writeByte(input neopixelPkg::bufferIndex_t byteAddress,
                           input neopixelPkg::pixelByte_t byteData);
    pixelWrite <= '{enable: 1'b1, address: byteAddress, data: byteData};
    @(posedge clk);
    pixelWrite <= '0; // strobe lasts one cycle
  endtask

  task automatic fillRandom();
    for (int a = 0; a <= `BUFFER_END; a++) begin
      writeByte(neopixelPkg::bufferIndex_t'(a), neopixelPkg::pixelByte_t'($random(seed)));
    end
  endtask

  // only has addresses to try when BUFFER_END+1 is not a power of two
  task automatic writeOutOfRange();
    for (int a = `BUFFER_END + 1; a < (1 << $bits(neopixelPkg::bufferIndex_t)); a++) begin
      writeByte(neopixelPkg::bufferIndex_t'(a), 8'hff);
    end
  endtask

  task automatic launchFrame(input logic wide);
    mode32 <= wide;
    start  <= 1'b1;
    @(posedge clk);
    start  <= 1'b0;
  endtask

  task automatic waitForBusy();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!busy && cycles < BUSY_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!busy) begin
      $display("timed out waiting for busy after a start pulse");
      tbErrors++;
      finishRun();
    end
  endtask

  task automatic waitForDone();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!frameDone && cycles < DONE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!frameDone) begin
      $display("timed out waiting for frameDone after %0d clocks", DONE_LIMIT);
      tbErrors++;
      finishRun();
    end
  endtask

  task automatic sendFrame(input logic wide);
    launchFrame(wide);
    waitForDone();
  endtask

  // nothing may happen for a while, a second frame would show up here
  task automatic checkQuiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      if (busy || frameDone) begin
        $display("[FAIL] %0t: busy %b frameDone %b after the frame ended", $time, busy, frameDone);
        tbErrors++;
      end
    end
  endtask

  initial begin
    reset      = 1'b1;
    pixelWrite = '0;
    run        = 1'b0;
    mode32     = 1'b0;
    start      = 1'b0;
    tbErrors   = 0;
    seed       = 32'h4b0c_0595;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    run <= 1'b1;
    fillRandom();
    sendFrame(1'b1); // four pixels with padding bytes

    fillRandom();
    sendFrame(1'b0); // sixteen packed pixels

    // writes during a frame and past the end must not reach the next frame
    fillRandom();
    writeOutOfRange();
    launchFrame(1'b1);
    waitForBusy();
    repeat (8) begin
      writeByte(neopixelPkg::bufferIndex_t'($random(seed)),
                neopixelPkg::pixelByte_t'($random(seed)));
    end
    waitForDone();
    sendFrame(1'b1);

    run <= 1'b0; // same timing, dark line
    sendFrame(1'b1);
    run <= 1'b1;

    // the second start also tries to switch the layout, both are ignored
    launchFrame(1'b1);
    waitForBusy();
    launchFrame(1'b0);
    waitForDone();
    checkQuiet(WIDE_FRAME + `LATCH_CYCLES + 10);

    finishRun();
  end

endmodule
